// ==== logic/freq_display_pkg.sv ====
// shared definitions for the frequency counter display subsystem
// widths, register map, FSM state types, APB structs and the segment table
// every RTL file refers to these by scoped name
`default_nettype none

package freq_display_pkg;

	// binary count and BCD result sizes
	localparam int count_width = 24;
	localparam int bcd_digits = 8;
	localparam int bcd_width = 4 * bcd_digits;
	localparam int shift_width = $clog2(count_width);
	localparam int data_width = 32;

	// display scanning, small so simulation sees every digit quickly
	localparam int scan_divide = 16;
	localparam int scan_width = $clog2(scan_divide);
	localparam int digit_width = $clog2(bcd_digits);
	localparam int dp_position = 0;

	// gate length after reset, in clocks
	localparam logic [count_width-1:0] gate_reset = 24'd1000;

	// patterns for segments g..a, active low, indexed by BCD digit
	// codes 10 to 15 are blank
	localparam logic [6:0] segment_table [16] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h10, 7'h7f, 7'h7f, 7'h7f, 7'h7f, 7'h7f, 7'h7f
	};

	// register map
	typedef enum logic [7:0] {
		reg_ctrl   = 8'h00,
		reg_gate   = 8'h04,
		reg_count  = 8'h08,
		reg_bcd    = 8'h0c,
		reg_status = 8'h10
	} apb_addr_t;

	typedef struct packed {
		logic sel;
		logic enable;
		logic write;
		apb_addr_t addr;
		logic [data_width-1:0] wdata;
	} apb_req_t;

	typedef struct packed {
		logic [data_width-1:0] rdata;
		logic ready;
		logic slverr;
	} apb_rsp_t;

	typedef enum logic {gate_idle, gate_gating} gate_state_t;
	typedef enum logic {conv_idle, conv_shifting} conv_state_t;

	// one finished gate window
	typedef struct packed {
		logic [count_width-1:0] value;
		logic valid;
	} count_result_t;

endpackage

`default_nettype wire

// ==== logic/edge_counter.sv ====
// counts rising edges of an asynchronous input over a gate window
// a start pulse opens a window of gate_length clocks; result.valid
// pulses once with the count when the window closes
`timescale 1ns/1ns
`default_nettype none

module edge_counter (
	input wire logic clock,
	input wire logic reset,
	input wire logic signal_in,
	input wire logic [freq_display_pkg::count_width-1:0] gate_length,
	input wire logic start,
	output logic busy,
	output freq_display_pkg::count_result_t result
);

	freq_display_pkg::gate_state_t state;
	logic sync_meta;
	logic sync_stable;
	logic sync_prev;
	logic rise;
	logic [freq_display_pkg::count_width-1:0] remaining;
	logic [freq_display_pkg::count_width-1:0] edge_count;
	logic [freq_display_pkg::count_width-1:0] edge_count_next;
	logic [freq_display_pkg::count_width-1:0] count_value;
	logic count_valid;

	// two flops against metastability, one more for edge detection
	always_ff @(posedge clock) begin
		if (reset) begin
			sync_meta <= 1'b0;
			sync_stable <= 1'b0;
			sync_prev <= 1'b0;
		end else begin
			sync_meta <= signal_in;
			sync_stable <= sync_meta;
			sync_prev <= sync_stable;
		end
	end

	assign rise = sync_stable & ~sync_prev;

	// holds at all ones instead of wrapping
	assign edge_count_next = (rise && edge_count != '1) ? edge_count + 1'b1 : edge_count;

	assign busy = (state == freq_display_pkg::gate_gating);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= freq_display_pkg::gate_idle;
			remaining <= '0;
			edge_count <= '0;
			count_valid <= 1'b0;
		end else begin
			count_valid <= 1'b0;
			case (state)
				freq_display_pkg::gate_idle: begin
					if (start) begin
						state <= freq_display_pkg::gate_gating;
						edge_count <= '0;
						// a zero length still gives a one-clock window
						remaining <= (gate_length == '0) ? '0 : gate_length - 1'b1;
					end
				end
				freq_display_pkg::gate_gating: begin
					if (remaining == '0) begin
						// last clock of the window, its edge still counts
						state <= freq_display_pkg::gate_idle;
						count_valid <= 1'b1;
					end else begin
						remaining <= remaining - 1'b1;
						edge_count <= edge_count_next;
					end
				end
				default: state <= freq_display_pkg::gate_idle;
			endcase
		end
	end

	// result value, only meaningful with valid
	always_ff @(posedge clock) begin
		if (state == freq_display_pkg::gate_gating && remaining == '0) begin
			count_value <= edge_count_next;
		end
	end

	assign result.value = count_value;
	assign result.valid = count_valid;

	// a result only comes out of a window that was open
	assert property (@(posedge clock) disable iff (reset)
		$rose(result.valid) |-> $past(state) == freq_display_pkg::gate_gating);

endmodule

`default_nettype wire

// ==== logic/bin_to_bcd.sv ====
// serial shift-and-add-three converter, 24-bit binary to eight BCD digits
// starts on result.valid, one bit per clock, bcd_done pulses 25 clocks later
`timescale 1ns/1ns
`default_nettype none

module bin_to_bcd (
	input wire logic clock,
	input wire logic reset,
	input freq_display_pkg::count_result_t result,
	output logic [freq_display_pkg::bcd_width-1:0] bcd_value,
	output logic bcd_done
);

	freq_display_pkg::conv_state_t state;
	logic [freq_display_pkg::count_width-1:0] binary;
	logic [freq_display_pkg::bcd_width-1:0] bcd_shift;
	logic [freq_display_pkg::bcd_width-1:0] bcd_adjusted;
	logic [freq_display_pkg::bcd_width-1:0] bcd_next;
	logic [freq_display_pkg::shift_width-1:0] shift_count;
	logic last_shift;

	// add three to any digit above four before it is doubled
	always_comb begin
		for (int i = 0; i < freq_display_pkg::bcd_digits; i++) begin
			if (bcd_shift[i*4 +: 4] > 4'd4) begin
				bcd_adjusted[i*4 +: 4] = bcd_shift[i*4 +: 4] + 4'd3;
			end else begin
				bcd_adjusted[i*4 +: 4] = bcd_shift[i*4 +: 4];
			end
		end
	end

	// msb of the binary value enters at the bottom
	assign bcd_next = {bcd_adjusted[freq_display_pkg::bcd_width-2:0],
		binary[freq_display_pkg::count_width-1]};

	assign last_shift = (shift_count ==
		freq_display_pkg::shift_width'(freq_display_pkg::count_width - 1));

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= freq_display_pkg::conv_idle;
			shift_count <= '0;
			bcd_done <= 1'b0;
		end else begin
			bcd_done <= 1'b0;
			case (state)
				freq_display_pkg::conv_idle: begin
					if (result.valid) begin
						state <= freq_display_pkg::conv_shifting;
						shift_count <= '0;
					end
				end
				freq_display_pkg::conv_shifting: begin
					// valid arriving here is dropped
					shift_count <= shift_count + 1'b1;
					if (last_shift) begin
						state <= freq_display_pkg::conv_idle;
						bcd_done <= 1'b1;
					end
				end
				default: state <= freq_display_pkg::conv_idle;
			endcase
		end
	end

	// datapath
	always_ff @(posedge clock) begin
		if (state == freq_display_pkg::conv_idle) begin
			binary <= result.value;
			bcd_shift <= '0;
		end else begin
			binary <= binary << 1;
			bcd_shift <= bcd_next;
			if (last_shift) begin
				bcd_value <= bcd_next;
			end
		end
	end

	for (genvar d = 0; d < freq_display_pkg::bcd_digits; d++) begin : g_digit_check
		assert property (@(posedge clock) disable iff (reset)
			bcd_done |-> bcd_value[d*4 +: 4] <= 4'd9);
	end

endmodule

`default_nettype wire

// ==== logic/digit_scanner.sv ====
// multiplexed driver for eight common-anode seven-segment digits
// latches a BCD value on bcd_done and lights one digit at a time
`timescale 1ns/1ns
`default_nettype none

module digit_scanner (
	input wire logic clock,
	input wire logic reset,
	input wire logic [freq_display_pkg::bcd_width-1:0] bcd_value,
	input wire logic bcd_done,
	output logic [7:0] segment,
	output logic [freq_display_pkg::bcd_digits-1:0] anode
);

	logic [freq_display_pkg::bcd_width-1:0] display;
	logic [freq_display_pkg::scan_width-1:0] prescale;
	logic [freq_display_pkg::digit_width-1:0] digit;
	logic [3:0] nibble;
	logic dp_lit;

	// display buffer, all blank codes until the first result
	always_ff @(posedge clock) begin
		if (reset) begin
			display <= '1;
		end else if (bcd_done) begin
			display <= bcd_value;
		end
	end

	// dwell scan_divide clocks per digit, digit 0 up to 7 then wrap
	always_ff @(posedge clock) begin
		if (reset) begin
			prescale <= '0;
			digit <= '0;
		end else if (prescale ==
			freq_display_pkg::scan_width'(freq_display_pkg::scan_divide - 1)) begin
			prescale <= '0;
			if (digit == freq_display_pkg::digit_width'(freq_display_pkg::bcd_digits - 1)) begin
				digit <= '0;
			end else begin
				digit <= digit + 1'b1;
			end
		end else begin
			prescale <= prescale + 1'b1;
		end
	end

	assign nibble = display[{digit, 2'b00} +: 4];
	assign dp_lit = (digit == freq_display_pkg::digit_width'(freq_display_pkg::dp_position));

	// dp in bit 7, active low like the segments
	assign segment = {~dp_lit, freq_display_pkg::segment_table[nibble]};
	assign anode = freq_display_pkg::bcd_digits'(1) << digit;

	assert property (@(posedge clock) disable iff (reset) $onehot(anode));

endmodule

`default_nettype wire

// ==== logic/apb_regs.sv ====
// APB register file for the frequency counter
// control and gate length from software, count and BCD result back,
// sticky new-result flag cleared by a status read
`timescale 1ns/1ns
`default_nettype none

module apb_regs (
	input wire logic clock,
	input wire logic reset,
	input freq_display_pkg::apb_req_t apb_req,
	output freq_display_pkg::apb_rsp_t apb_rsp,
	input wire logic busy,
	input freq_display_pkg::count_result_t result,
	input wire logic [freq_display_pkg::bcd_width-1:0] bcd_value,
	input wire logic bcd_done,
	output logic [freq_display_pkg::count_width-1:0] gate_length,
	output logic start
);

	logic access;
	logic addr_known;
	logic addr_writable;
	logic write_ok;
	logic status_read;
	logic continuous;
	logic new_result;
	logic [freq_display_pkg::count_width-1:0] gate_reg;
	logic [freq_display_pkg::count_width-1:0] count_reg;
	logic [freq_display_pkg::bcd_width-1:0] bcd_reg;
	logic [freq_display_pkg::data_width-1:0] read_mux;

	// access phase, always zero wait
	assign access = apb_req.sel & apb_req.enable;

	// address decode and read mux
	always_comb begin
		addr_known = 1'b1;
		addr_writable = 1'b0;
		read_mux = '0;
		case (apb_req.addr)
			freq_display_pkg::reg_ctrl: begin
				addr_writable = 1'b1;
				read_mux = {30'd0, continuous, 1'b0};
			end
			freq_display_pkg::reg_gate: begin
				addr_writable = 1'b1;
				read_mux = {8'd0, gate_reg};
			end
			freq_display_pkg::reg_count: read_mux = {8'd0, count_reg};
			freq_display_pkg::reg_bcd: read_mux = bcd_reg;
			freq_display_pkg::reg_status: read_mux = {30'd0, new_result, busy};
			default: addr_known = 1'b0;
		endcase
	end

	assign write_ok = access && apb_req.write && addr_known && addr_writable;
	assign status_read = access && !apb_req.write &&
		apb_req.addr == freq_display_pkg::reg_status;

	assign apb_rsp.rdata = access ? read_mux : '0;
	assign apb_rsp.ready = 1'b1;
	assign apb_rsp.slverr = access && (!addr_known || (apb_req.write && !addr_writable));

	assign gate_length = gate_reg;

	always_ff @(posedge clock) begin
		if (reset) begin
			continuous <= 1'b0;
			gate_reg <= freq_display_pkg::gate_reset;
			start <= 1'b0;
		end else begin
			if (write_ok && apb_req.addr == freq_display_pkg::reg_ctrl) begin
				continuous <= apb_req.wdata[1];
			end
			if (write_ok && apb_req.addr == freq_display_pkg::reg_gate) begin
				gate_reg <= apb_req.wdata[freq_display_pkg::count_width-1:0];
			end
			// single shot from software, or rearm after each conversion
			start <= (write_ok && apb_req.addr == freq_display_pkg::reg_ctrl &&
				apb_req.wdata[0]) || (continuous && bcd_done);
		end
	end

	// results, overwritten whether read or not
	always_ff @(posedge clock) begin
		if (reset) begin
			count_reg <= '0;
			bcd_reg <= '0;
			new_result <= 1'b0;
		end else begin
			if (result.valid) begin
				count_reg <= result.value;
			end
			if (bcd_done) begin
				bcd_reg <= bcd_value;
			end
			// a fresh result wins over a clearing read
			if (bcd_done) begin
				new_result <= 1'b1;
			end else if (status_read) begin
				new_result <= 1'b0;
			end
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		apb_rsp.slverr |-> apb_req.sel && apb_req.enable);

endmodule

`default_nettype wire

// ==== logic/freq_display_top.sv ====
// frequency counter with seven-segment readout
// APB for control and results, signal_in as the measured input,
// segment and anode drive the multiplexed display
`timescale 1ns/1ns
`default_nettype none

module freq_display_top (
	input wire logic clock,
	input wire logic reset,
	input freq_display_pkg::apb_req_t apb_req,
	output freq_display_pkg::apb_rsp_t apb_rsp,
	input wire logic signal_in,
	output logic [7:0] segment,
	output logic [7:0] anode
);

	logic [freq_display_pkg::count_width-1:0] gate_length;
	logic start;
	logic busy;
	freq_display_pkg::count_result_t result;
	logic [freq_display_pkg::bcd_width-1:0] bcd_value;
	logic bcd_done;

	// control path
	apb_regs apb_regs_inst (
		.clock(clock),
		.reset(reset),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.busy(busy),
		.result(result),
		.bcd_value(bcd_value),
		.bcd_done(bcd_done),
		.gate_length(gate_length),
		.start(start)
	);

	// input side
	edge_counter edge_counter_inst (
		.clock(clock),
		.reset(reset),
		.signal_in(signal_in),
		.gate_length(gate_length),
		.start(start),
		.busy(busy),
		.result(result)
	);

	bin_to_bcd bin_to_bcd_inst (
		.clock(clock),
		.reset(reset),
		.result(result),
		.bcd_value(bcd_value),
		.bcd_done(bcd_done)
	);

	// output side
	digit_scanner digit_scanner_inst (
		.clock(clock),
		.reset(reset),
		.bcd_value(bcd_value),
		.bcd_done(bcd_done),
		.segment(segment),
		.anode(anode)
	);

endmodule

`default_nettype wire

// ==== verif/freq_display_tb.sv ====
// testbench for freq_display_top
// runs a table of gate lengths and square-wave periods through APB,
// checks counts, BCD values, the scanned display and bus errors
`timescale 1ns/1ns
`default_nettype none

module freq_display_tb;

	// gate in clocks, half-period in clocks (0 holds the input low), mode
	typedef struct packed {
		int gate;
		int half;
		logic continuous;
	} row_t;

	localparam int num_rows = 6;
	localparam row_t rows [num_rows] = '{
		'{200, 2, 1'b0},
		'{300, 3, 1'b0},
		'{257, 5, 1'b0},
		'{1000, 1, 1'b0},
		'{150, 0, 1'b0},
		'{120, 4, 1'b1}
	};

	// g..a, active low, digits 0 to 9, rest blank
	localparam logic [6:0] digit_segments [16] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h10, 7'h7f, 7'h7f, 7'h7f, 7'h7f, 7'h7f, 7'h7f
	};

	logic clock;
	logic reset;
	freq_display_pkg::apb_req_t apb_req;
	freq_display_pkg::apb_rsp_t apb_rsp;
	logic signal_in;
	logic [7:0] segment;
	logic [7:0] anode;

	// square-wave generator settings
	int gen_half = 0;
	int gen_phase = 0;

	int errors = 0;
	int test_errors = 0;
	int tests = 0;
	int failed_tests = 0;

	freq_display_top freq_display_top_inst (
		.clock(clock),
		.reset(reset),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.signal_in(signal_in),
		.segment(segment),
		.anode(anode)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// measured input, updated 5 ns after each rising edge
	initial begin
		signal_in = 1'b0;
		forever begin
			@(posedge clock);
			#5;
			if (gen_half == 0) begin
				signal_in = 1'b0;
			end else begin
				signal_in = (gen_phase < gen_half);
				gen_phase = (gen_phase + 1) % (2 * gen_half);
			end
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("mismatch %s: got %h expected %h", name, got, expected);
			errors++;
			test_errors++;
		end
	endtask

	// one setup phase, one access phase, response sampled mid-cycle
	task automatic apb_transfer(input logic write, input logic [7:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int waits;
		waits = 0;
		@(posedge clock);
		#5;
		apb_req.sel = 1'b1;
		apb_req.enable = 1'b0;
		apb_req.write = write;
		apb_req.addr = freq_display_pkg::apb_addr_t'(addr);
		apb_req.wdata = wdata;
		@(posedge clock);
		#5;
		apb_req.enable = 1'b1;
		@(negedge clock);
		while (!apb_rsp.ready && waits < 16) begin
			@(negedge clock);
			waits++;
		end
		if (!apb_rsp.ready) begin
			$display("APB transfer at address %h never completed, ready stayed low", addr);
			errors++;
			test_errors++;
		end
		rdata = apb_rsp.rdata;
		err = apb_rsp.slverr;
		@(posedge clock);
		#5;
		apb_req.sel = 1'b0;
		apb_req.enable = 1'b0;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
		output logic err);
		logic [31:0] unused_rdata;
		apb_transfer(1'b1, addr, data, unused_rdata, err);
	endtask

	task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
		output logic err);
		apb_transfer(1'b0, addr, 32'd0, data, err);
	endtask

	// new phase is picked before the first edge the generator sees
	task automatic set_signal(input int half);
		@(posedge clock);
		#1;
		gen_half = half;
		if (half > 0) begin
			gen_phase = int'($urandom % 32'(2 * half));
		end
	endtask

	function automatic logic [31:0] decimal_digits(input int unsigned value);
		logic [31:0] digits;
		int unsigned rest;
		rest = value;
		for (int i = 0; i < 8; i++) begin
			digits[i*4 +: 4] = 4'(rest % 10);
			rest = rest / 10;
		end
		return digits;
	endfunction

	// polls status, the read that sees the flag also clears it
	task automatic wait_new_result(input int limit);
		logic [31:0] status;
		logic err;
		int polls;
		status = '0;
		polls = 0;
		while (!status[1] && polls < limit) begin
			read_reg(freq_display_pkg::reg_status, status, err);
			polls++;
		end
		if (!status[1]) begin
			$display("timeout, no new result after %0d status reads", polls);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_result(input int floor_count, input bit allow_extra,
		output logic [31:0] count);
		logic [31:0] bcd;
		logic [31:0] expected;
		logic err;
		read_reg(freq_display_pkg::reg_count, count, err);
		read_reg(freq_display_pkg::reg_bcd, bcd, err);
		// the window phase can let one extra edge in, a still input has none
		expected = (allow_extra && count > 32'(floor_count)) ?
			32'(floor_count + 1) : 32'(floor_count);
		check_value("reg_count", count, expected);
		check_value("reg_bcd", bcd, decimal_digits(count));
	endtask

	// one full scan, every lit position against its digit
	task automatic check_display(input logic [31:0] bcd);
		logic [7:0] expected;
		logic [7:0] seen;
		int pos;
		seen = '0;
		for (int n = 0; n < 8 * freq_display_pkg::scan_divide; n++) begin
			@(negedge clock);
			if (!$onehot(anode)) begin
				$display("anode is not one-hot, shows %h", anode);
				errors++;
				test_errors++;
			end else begin
				pos = $clog2(anode);
				seen = seen | anode;
				expected[6:0] = digit_segments[bcd[pos*4 +: 4]];
				// dp is active low too
				expected[7] = (pos != freq_display_pkg::dp_position);
				check_value("segment", {24'd0, segment}, {24'd0, expected});
			end
		end
		check_value("anode positions", {24'd0, seen}, 32'hff);
	endtask

	task automatic run_row(input int index, input row_t row);
		logic [31:0] status;
		logic [31:0] count;
		logic err;
		int floor_count;
		int limit;
		bit allow_extra;
		test_errors = 0;
		floor_count = (row.half == 0) ? 0 : row.gate / (2 * row.half);
		allow_extra = (row.half != 0);
		limit = row.gate / 3 + 40;
		set_signal(row.half);
		// drop any stale flag first
		read_reg(freq_display_pkg::reg_status, status, err);
		write_reg(freq_display_pkg::reg_gate, 32'(row.gate), err);
		write_reg(freq_display_pkg::reg_ctrl, row.continuous ? 32'd3 : 32'd1, err);
		// window just opened, far from its end
		read_reg(freq_display_pkg::reg_status, status, err);
		check_value("status busy", {31'd0, status[0]}, 32'd1);
		for (int r = 0; r < (row.continuous ? 2 : 1); r++) begin
			wait_new_result(limit);
			check_result(floor_count, allow_extra, count);
		end
		if (row.continuous) begin
			read_reg(freq_display_pkg::reg_status, status, err);
			check_value("status new result", {31'd0, status[1]}, 32'd0);
			// third window is already gating, let it finish
			write_reg(freq_display_pkg::reg_ctrl, 32'd0, err);
			wait_new_result(limit);
			check_result(floor_count, allow_extra, count);
			read_reg(freq_display_pkg::reg_status, status, err);
			check_value("status", status, 32'd0);
		end
		check_display(decimal_digits(count));
		tests++;
		if (test_errors != 0) begin
			failed_tests++;
		end
		$display("test %0d: gate %0d half-period %0d %s, %s", index, row.gate, row.half,
			row.continuous ? "continuous" : "single", (test_errors == 0) ? "ok" : "failed");
	endtask

	// read-only and unknown addresses
	task automatic check_bus_errors(input int index);
		logic [31:0] count_before;
		logic [31:0] gate_before;
		logic [31:0] data;
		logic err;
		test_errors = 0;
		read_reg(freq_display_pkg::reg_count, count_before, err);
		read_reg(freq_display_pkg::reg_gate, gate_before, err);
		check_value("slverr on gate read", {31'd0, err}, 32'd0);
		write_reg(freq_display_pkg::reg_count, 32'h00abcdef, err);
		check_value("slverr on count write", {31'd0, err}, 32'd1);
		read_reg(freq_display_pkg::reg_count, data, err);
		check_value("reg_count", data, count_before);
		write_reg(8'h20, 32'hffffffff, err);
		check_value("slverr on unknown write", {31'd0, err}, 32'd1);
		read_reg(8'h24, data, err);
		check_value("slverr on unknown read", {31'd0, err}, 32'd1);
		read_reg(freq_display_pkg::reg_gate, data, err);
		check_value("reg_gate", data, gate_before);
		read_reg(freq_display_pkg::reg_ctrl, data, err);
		check_value("reg_ctrl", data, 32'd0);
		tests++;
		if (test_errors != 0) begin
			failed_tests++;
		end
		$display("test %0d: bus errors, %s", index, (test_errors == 0) ? "ok" : "failed");
	endtask

	initial begin
		void'($urandom(32'he487f568));
		reset = 1'b1;
		apb_req = '0;
		repeat (8) @(posedge clock);
		#5;
		reset = 1'b0;
		for (int t = 0; t < num_rows; t++) begin
			run_row(t, rows[t]);
		end
		check_bus_errors(num_rows);
		$display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== freq_display.f ====
logic/freq_display_pkg.sv
logic/edge_counter.sv
logic/bin_to_bcd.sv
logic/digit_scanner.sv
logic/apb_regs.sv
logic/freq_display_top.sv
verif/freq_display_tb.sv

// ==== build.sh ====
#!/bin/sh
# compile and run the frequency counter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f freq_display.f \
	--top-module freq_display_tb -o freq_display_sim
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/freq_display_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "^TEST RESULT: PASS$" sim.log; then
	exit 0
else
	echo "pass message not found in sim.log"
	exit 1
fi
